//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= build.f
TB_TOP    ?= tb_line_mem_ctrl
RTL_TOP   ?= line_mem_ctrl
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP)

$(OBJ_DIR)/V$(TB_TOP): $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TB_TOP)
	./$(OBJ_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "TEST PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- build.f
logic/line_mem_pkg.sv
logic/beat_counter.sv
logic/burst_adapter.sv
logic/arb_fsm.sv
logic/line_mem_ctrl.sv
dv/tb_line_mem_ctrl.sv

//--- dv/tb_line_mem_ctrl.sv
`timescale 1ns/100ps

module tb_line_mem_ctrl;

    localparam int TIMEOUT = 500;   // cycles per wait

    logic         clk;
    logic         rst;
    logic         i_read;
    logic [31:0]  i_addr;
    logic [255:0] i_rdata;
    logic         i_resp;
    logic         d_read;
    logic         d_write;
    logic [31:0]  d_addr;
    logic [255:0] d_wdata;
    logic [255:0] d_rdata;
    logic         d_resp;
    logic [31:0]  bmem_addr;
    logic         bmem_read;
    logic         bmem_write;
    logic [63:0]  bmem_wdata;
    logic         bmem_ready;
    logic [63:0]  bmem_rdata;
    logic         bmem_rvalid;

    integer       seed;
    int           errors;
    int           err_mark;
    int           tests_ok;
    int           tests_bad;
    int           i_issued;
    int           d_issued;
    int           i_seen;
    int           d_seen;
    int           wr_done;
    int           wbeats;
    logic [255:0] mem_q [int];      // memory contents by line address
    logic [255:0] ref_q [int];      // expected contents
    logic         rd_active;
    int           rd_idx;
    int           rd_wait;
    logic [255:0] rd_line;
    int           wr_idx;
    logic [255:0] wr_line;
    logic         prev_write;
    logic         bp_mode;          // long ready-low stretches
    int           low_run;
    int           order_q [$];      // 0 instr, 1 data

    line_mem_ctrl dut_i (
        .clk (clk), .rst (rst),
        .i_read_i (i_read), .i_addr_i (i_addr), .i_rdata_o (i_rdata), .i_resp_o (i_resp),
        .d_read_i (d_read), .d_write_i (d_write), .d_addr_i (d_addr), .d_wdata_i (d_wdata),
        .d_rdata_o (d_rdata), .d_resp_o (d_resp),
        .bmem_addr_o (bmem_addr), .bmem_read_o (bmem_read), .bmem_write_o (bmem_write),
        .bmem_wdata_o (bmem_wdata), .bmem_ready_i (bmem_ready), .bmem_rdata_i (bmem_rdata),
        .bmem_rvalid_i (bmem_rvalid)
    );

    always #50 clk = ~clk;

    function automatic logic [255:0] fill_line(int la);
        logic [255:0] v;
        for (int b = 0; b < 4; b++) begin
            v[b*64 +: 64] = {la ^ 32'h5a5a_0000, la * 7 + b};   // beat index in low word
        end
        return v;
    endfunction

    function automatic logic [255:0] mem_line(int la);
        return mem_q.exists(la) ? mem_q[la] : fill_line(la);
    endfunction

    function automatic logic [255:0] ref_line(int la);
        return ref_q.exists(la) ? ref_q[la] : fill_line(la);
    endfunction

    function automatic int line_of(logic [31:0] a);
        return int'(a & 32'hffff_ffe0);
    endfunction

    function automatic logic [31:0] rand_addr();
        return 32'h0000_1000 + (($random(seed) & 7) << 5) + ($random(seed) & 31);
    endfunction

    task automatic log_error(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        errors++;
    endtask

    // memory monitor, outputs are stable at the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            assert (!bmem_read || bmem_ready) else log_error("read pulse while ready low");
            assert (!(bmem_write && !prev_write) || bmem_ready)
                else log_error("write strobe rose while ready low");
            if (bmem_read) begin
                assert (bmem_addr[4:0] == 5'd0)
                    else log_error($sformatf("unaligned read address %h", bmem_addr));
                rd_line   = mem_line(int'(bmem_addr));
                rd_idx    = 0;
                rd_wait   = $random(seed) & 3;
                rd_active = 1'b1;
            end
            if (bmem_write && bmem_ready) begin
                wr_line[wr_idx*64 +: 64] = bmem_wdata;
                wr_idx++;
                wbeats++;
                if (wr_idx == 4) begin
                    mem_q[int'(bmem_addr)] = wr_line;   // commit after fourth beat
                    wr_idx = 0;
                end
            end
            if (i_resp) i_seen++;
            if (d_resp) d_seen++;
        end
        prev_write = bmem_write;
    end

    // memory driver, ready and read beats
    always @(posedge clk) begin
        logic in_reset;
        in_reset = rst;                 // reset level the DUT saw at this edge
        #10;
        if (in_reset) begin
            bmem_ready  = 1'b0;
            bmem_rvalid = 1'b0;
        end else begin
            if (low_run > 0) begin
                bmem_ready = 1'b0;
                low_run--;
            end else if (bp_mode && ($random(seed) & 7) == 0) begin
                bmem_ready = 1'b0;
                low_run    = $random(seed) & 7;
            end else begin
                bmem_ready = ($random(seed) & 3) != 0;   // about 75% high
            end
            bmem_rvalid = 1'b0;
            if (rd_active) begin
                if (rd_wait > 0) begin
                    rd_wait--;
                end else if (($random(seed) & 3) != 0) begin
                    bmem_rvalid = 1'b1;
                    bmem_rdata  = rd_line[rd_idx*64 +: 64];
                    rd_idx++;
                    if (rd_idx == 4) rd_active = 1'b0;
                end
            end
        end
    end

    task automatic wait_resp(input bit instr, output bit ok);
        int n;
        ok = 1'b0;
        n  = 0;
        while (!ok && n < TIMEOUT) begin
            @(negedge clk);
            ok = instr ? i_resp : d_resp;
            n++;
        end
        if (!ok) begin
            $display("timed out waiting for the %s response", instr ? "instruction" : "data");
            errors++;
        end
    endtask

    task automatic instr_read(input logic [31:0] a);
        bit           ok;
        logic [255:0] exp;
        i_addr = a;
        i_read = 1'b1;
        i_issued++;
        wait_resp(1'b1, ok);
        if (ok) begin
            exp = ref_line(line_of(a));
            assert (i_rdata == exp)
                else log_error($sformatf("instr read %h got %h expected %h", a, i_rdata, exp));
            order_q.push_back(0);
        end
        @(posedge clk);
        #10;
        i_read = 1'b0;
    endtask

    task automatic data_op(input bit wr, input logic [31:0] a);
        bit           ok;
        logic [255:0] exp;
        for (int k = 0; k < 8; k++) begin
            d_wdata[k*32 +: 32] = $random(seed);
        end
        d_addr  = a;
        d_read  = !wr;
        d_write = wr;
        d_issued++;
        wait_resp(1'b0, ok);
        if (ok) begin
            if (wr) begin
                ref_q[line_of(a)] = d_wdata;   // model follows the write response
                wr_done++;
            end else begin
                exp = ref_line(line_of(a));
                assert (d_rdata == exp)
                    else log_error($sformatf("data read %h got %h expected %h", a, d_rdata, exp));
            end
            order_q.push_back(1);
        end
        @(posedge clk);
        #10;
        d_read  = 1'b0;
        d_write = 1'b0;
    endtask

    task automatic mixed_traffic(input int n);
        fork
            repeat (n) instr_read(rand_addr());
            repeat (n) data_op($random(seed) & 1, rand_addr());
        join
    endtask

    task automatic end_test(input string name);
        if (errors == err_mark) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        seed        = 38901;
        clk         = 0;
        rst         = 1;
        i_read      = 0;
        i_addr      = 0;
        d_read      = 0;
        d_write     = 0;
        d_addr      = 0;
        d_wdata     = 0;
        bmem_ready  = 0;
        bmem_rdata  = 0;
        bmem_rvalid = 0;
        errors      = 0;
        err_mark    = 0;
        tests_ok    = 0;
        tests_bad   = 0;
        i_issued    = 0;
        d_issued    = 0;
        i_seen      = 0;
        d_seen      = 0;
        wr_done     = 0;
        wbeats      = 0;
        rd_active   = 0;
        rd_idx      = 0;
        rd_wait     = 0;
        wr_idx      = 0;
        prev_write  = 0;
        bp_mode     = 0;
        low_run     = 0;
        repeat (16) @(posedge clk);
        #10;
        rst = 0;

        repeat (12) begin
            @(negedge clk);
            assert (!bmem_read && !bmem_write && !i_resp && !d_resp)
                else log_error("strobe or response high with no request");
        end
        @(posedge clk);
        #10;
        end_test("reset");

        repeat (20) instr_read(rand_addr());
        end_test("instr_reads");

        repeat (20) data_op(1'b1, rand_addr());
        repeat (10) data_op(1'b0, rand_addr());
        repeat (10) instr_read(rand_addr());
        end_test("write_then_read");

        order_q.delete();
        mixed_traffic(12);
        for (int k = 1; k < order_q.size(); k++) begin
            assert (order_q[k] != order_q[k-1])
                else log_error($sformatf("response %0d repeats the same side", k));
        end
        end_test("round_robin");

        bp_mode = 1'b1;
        mixed_traffic(15);
        repeat (4) @(negedge clk);
        assert (i_seen == i_issued && d_seen == d_issued)
            else log_error($sformatf("responses %0d/%0d for requests %0d/%0d",
                                     i_seen, d_seen, i_issued, d_issued));
        assert (wbeats == 4 * wr_done)
            else log_error($sformatf("%0d write beats for %0d writes", wbeats, wr_done));
        end_test("back_pressure");

        $display("summary: %0d tests ok, %0d tests failed", tests_ok, tests_bad);
        if (errors == 0 && tests_bad == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- logic/arb_fsm.sv
`timescale 1ns/100ps

module arb_fsm (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               i_read_i,
    input  logic                               d_read_i,
    input  logic                               d_write_i,
    input  logic [line_mem_pkg::ADDR_BITS-1:0] i_addr_i,
    input  logic [line_mem_pkg::ADDR_BITS-1:0] d_addr_i,
    input  logic                               bmem_ready_i,
    input  logic                               bmem_rvalid_i,
    input  logic                               last_beat_i,
    output logic                               bmem_read_o,
    output logic                               bmem_write_o,
    output logic [line_mem_pkg::ADDR_BITS-1:0] bmem_addr_o,
    output line_mem_pkg::req_src_t             grant_src_o,
    output logic                               i_resp_o,
    output logic                               d_resp_o,
    output logic                               beat_clear_o,
    output logic                               beat_step_o,
    output logic                               line_load_o,
    output logic                               beat_shift_in_o,
    output logic                               beat_shift_out_o
);

    line_mem_pkg::arb_state_t state_q;
    line_mem_pkg::arb_state_t state_d;
    line_mem_pkg::mem_op_t    op_q;
    line_mem_pkg::mem_op_t    op_d;
    line_mem_pkg::req_src_t   src_q;    // last source served
    line_mem_pkg::req_src_t   src_d;
    logic [line_mem_pkg::ADDR_BITS-1:0] addr_q;
    logic [line_mem_pkg::ADDR_BITS-1:0] sel_addr;
    logic i_pend;
    logic d_pend;
    logic grant;
    logic wr_live_q;                    // write strobe already up
    logic in_burst;
    logic beat_xfer;

    assign i_pend = i_read_i;
    assign d_pend = d_read_i | d_write_i;
    assign grant  = (state_q == line_mem_pkg::ST_IDLE) && (i_pend || d_pend);

    // round robin, the side not served last wins a tie
    always_comb begin
        src_d = src_q;
        if (i_pend && d_pend) begin
            src_d = (src_q == line_mem_pkg::SRC_INSTR) ? line_mem_pkg::SRC_DATA
                                                       : line_mem_pkg::SRC_INSTR;
        end else if (i_pend) begin
            src_d = line_mem_pkg::SRC_INSTR;
        end else if (d_pend) begin
            src_d = line_mem_pkg::SRC_DATA;
        end
    end

    assign op_d = (src_d == line_mem_pkg::SRC_DATA && d_write_i) ? line_mem_pkg::OP_WRITE
                                                                 : line_mem_pkg::OP_READ;
    assign sel_addr = (src_d == line_mem_pkg::SRC_DATA) ? d_addr_i : i_addr_i;

    always_comb begin
        state_d = state_q;
        case (state_q)
            line_mem_pkg::ST_IDLE: begin
                if (grant) begin
                    state_d = (op_d == line_mem_pkg::OP_WRITE) ? line_mem_pkg::ST_WR_BEATS
                                                               : line_mem_pkg::ST_RD_ISSUE;
                end
            end
            line_mem_pkg::ST_RD_ISSUE: begin
                if (bmem_ready_i) begin
                    state_d = line_mem_pkg::ST_RD_BEATS;   // pulse goes out this cycle
                end
            end
            line_mem_pkg::ST_RD_BEATS, line_mem_pkg::ST_WR_BEATS: begin
                if (beat_step_o && last_beat_i) begin
                    state_d = line_mem_pkg::ST_RESP;
                end
            end
            default: begin
                state_d = line_mem_pkg::ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q   <= line_mem_pkg::ST_IDLE;
            src_q     <= line_mem_pkg::SRC_DATA;   // instruction side wins first tie
            op_q      <= line_mem_pkg::OP_READ;
            wr_live_q <= 1'b0;
        end else begin
            state_q   <= state_d;
            wr_live_q <= (state_q == line_mem_pkg::ST_WR_BEATS) &&
                         (state_d == line_mem_pkg::ST_WR_BEATS) && bmem_write_o;
            if (grant) begin
                src_q <= src_d;
                op_q  <= op_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            addr_q <= {sel_addr[line_mem_pkg::ADDR_BITS-1:line_mem_pkg::OFFSET_BITS],
                       {line_mem_pkg::OFFSET_BITS{1'b0}}};   // line aligned
        end
    end

    assign in_burst = (state_q == line_mem_pkg::ST_RD_BEATS) ||
                      (state_q == line_mem_pkg::ST_WR_BEATS);
    assign beat_xfer = (op_q == line_mem_pkg::OP_READ) ? bmem_rvalid_i
                                                       : (bmem_write_o && bmem_ready_i);

    assign bmem_read_o  = (state_q == line_mem_pkg::ST_RD_ISSUE) && bmem_ready_i;
    // first beat waits for ready, later beats hold through back-pressure
    assign bmem_write_o = (state_q == line_mem_pkg::ST_WR_BEATS) && (wr_live_q || bmem_ready_i);
    assign bmem_addr_o  = addr_q;
    assign grant_src_o  = src_q;

    assign i_resp_o = (state_q == line_mem_pkg::ST_RESP) && (src_q == line_mem_pkg::SRC_INSTR);
    assign d_resp_o = (state_q == line_mem_pkg::ST_RESP) && (src_q == line_mem_pkg::SRC_DATA);

    assign beat_clear_o     = grant;
    assign beat_step_o      = in_burst && beat_xfer;
    assign line_load_o      = grant && (op_d == line_mem_pkg::OP_WRITE);   // dirty line in
    assign beat_shift_in_o  = beat_step_o && (op_q == line_mem_pkg::OP_READ);
    assign beat_shift_out_o = beat_step_o && (op_q == line_mem_pkg::OP_WRITE);

    a_strobes_excl: assert property (@(posedge clk) disable iff (rst)
        !(bmem_read_o && bmem_write_o))
        else $error("read and write strobes high together");

    a_strobe_ready: assert property (@(posedge clk) disable iff (rst)
        ($rose(bmem_read_o) || $rose(bmem_write_o)) |-> bmem_ready_i)
        else $error("memory strobe rose while ready low");

    a_rvalid_state: assert property (@(posedge clk) disable iff (rst)
        bmem_rvalid_i |-> (state_q == line_mem_pkg::ST_RD_BEATS))
        else $error("rvalid outside a read burst");

    a_resp_excl: assert property (@(posedge clk) disable iff (rst)
        !(i_resp_o && d_resp_o))
        else $error("both responses high together");

endmodule

//--- logic/beat_counter.sv
`timescale 1ns/100ps

module beat_counter (
    input  logic clk,
    input  logic rst,
    input  logic beat_clear_i,
    input  logic beat_step_i,
    output logic last_beat_o
);

    // one extra bit so an overrun past the last beat is visible
    logic [line_mem_pkg::BEAT_IDX_BITS:0] cnt_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_q <= '0;
        end else if (beat_clear_i) begin
            cnt_q <= '0;                // new burst
        end else if (beat_step_i) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    assign last_beat_o = (int'(cnt_q) == line_mem_pkg::BEATS - 1);

    a_no_overrun: assert property (@(posedge clk) disable iff (rst)
        beat_step_i |-> (int'(cnt_q) < line_mem_pkg::BEATS))
        else $error("beat counter stepped past the last beat");

endmodule

//--- logic/burst_adapter.sv
`timescale 1ns/100ps

module burst_adapter (
    input  logic                               clk,
    input  logic                               rst,
    input  logic                               line_load_i,
    input  logic                               beat_shift_in_i,
    input  logic                               beat_shift_out_i,
    input  logic [line_mem_pkg::LINE_BITS-1:0] wline_i,
    input  logic [line_mem_pkg::BEAT_BITS-1:0] bmem_rdata_i,
    output logic [line_mem_pkg::BEAT_BITS-1:0] bmem_wdata_o,
    output logic [line_mem_pkg::LINE_BITS-1:0] line_o
);

    // shared by both directions, only one burst runs at a time
    logic [line_mem_pkg::LINE_BITS-1:0] line_q;

    always_ff @(posedge clk) begin
        if (rst) begin
            line_q <= '0;
        end else if (line_load_i) begin
            line_q <= wline_i;                  // dirty line from data side
        end else if (beat_shift_in_i) begin
            // new beat enters at the top, lowest beat ends up at the bottom
            line_q <= {bmem_rdata_i,
                       line_q[line_mem_pkg::LINE_BITS-1:line_mem_pkg::BEAT_BITS]};
        end else if (beat_shift_out_i) begin
            // rotate so the line is back in order after the burst
            line_q <= {line_q[line_mem_pkg::BEAT_BITS-1:0],
                       line_q[line_mem_pkg::LINE_BITS-1:line_mem_pkg::BEAT_BITS]};
        end
    end

    assign bmem_wdata_o = line_q[line_mem_pkg::BEAT_BITS-1:0];   // current write beat
    assign line_o       = line_q;

endmodule

//--- logic/line_mem_ctrl.sv
`timescale 1ns/100ps

module line_mem_ctrl (
    input  logic                               clk,
    input  logic                               rst,

    // instruction side, reads only
    input  logic                               i_read_i,
    input  logic [line_mem_pkg::ADDR_BITS-1:0] i_addr_i,
    output logic [line_mem_pkg::LINE_BITS-1:0] i_rdata_o,
    output logic                               i_resp_o,

    // data side, reads and dirty line writes
    input  logic                               d_read_i,
    input  logic                               d_write_i,
    input  logic [line_mem_pkg::ADDR_BITS-1:0] d_addr_i,
    input  logic [line_mem_pkg::LINE_BITS-1:0] d_wdata_i,
    output logic [line_mem_pkg::LINE_BITS-1:0] d_rdata_o,
    output logic                               d_resp_o,

    // burst memory
    output logic [line_mem_pkg::ADDR_BITS-1:0] bmem_addr_o,
    output logic                               bmem_read_o,
    output logic                               bmem_write_o,
    output logic [line_mem_pkg::BEAT_BITS-1:0] bmem_wdata_o,
    input  logic                               bmem_ready_i,
    input  logic [line_mem_pkg::BEAT_BITS-1:0] bmem_rdata_i,
    input  logic                               bmem_rvalid_i
);

    logic                               last_beat;
    logic                               beat_clear;
    logic                               beat_step;
    logic                               line_load;
    logic                               beat_shift_in;
    logic                               beat_shift_out;
    logic [line_mem_pkg::LINE_BITS-1:0] line;

    arb_fsm arb_fsm_i (
        .clk              (clk),
        .rst              (rst),
        .i_read_i         (i_read_i),
        .d_read_i         (d_read_i),
        .d_write_i        (d_write_i),
        .i_addr_i         (i_addr_i),
        .d_addr_i         (d_addr_i),
        .bmem_ready_i     (bmem_ready_i),
        .bmem_rvalid_i    (bmem_rvalid_i),
        .last_beat_i      (last_beat),
        .bmem_read_o      (bmem_read_o),
        .bmem_write_o     (bmem_write_o),
        .bmem_addr_o      (bmem_addr_o),
        .grant_src_o      (),               // only of interest in waveforms
        .i_resp_o         (i_resp_o),
        .d_resp_o         (d_resp_o),
        .beat_clear_o     (beat_clear),
        .beat_step_o      (beat_step),
        .line_load_o      (line_load),
        .beat_shift_in_o  (beat_shift_in),
        .beat_shift_out_o (beat_shift_out)
    );

    beat_counter beat_counter_i (
        .clk          (clk),
        .rst          (rst),
        .beat_clear_i (beat_clear),
        .beat_step_i  (beat_step),
        .last_beat_o  (last_beat)
    );

    burst_adapter burst_adapter_i (
        .clk              (clk),
        .rst              (rst),
        .line_load_i      (line_load),
        .beat_shift_in_i  (beat_shift_in),
        .beat_shift_out_i (beat_shift_out),
        .wline_i          (d_wdata_i),
        .bmem_rdata_i     (bmem_rdata_i),
        .bmem_wdata_o     (bmem_wdata_o),
        .line_o           (line)
    );

    // both sides see the line, each samples it on its own response
    assign i_rdata_o = line;
    assign d_rdata_o = line;

endmodule

//--- logic/line_mem_pkg.sv
package line_mem_pkg;

    localparam int ADDR_BITS     = 32;
    localparam int LINE_BITS     = 256;
    localparam int BEAT_BITS     = 64;
    localparam int BEATS         = 4;   // beats per line
    localparam int BEAT_IDX_BITS = 2;
    localparam int OFFSET_BITS   = 5;   // byte offset inside a line

    // arbiter states
    typedef enum logic [2:0] {
        ST_IDLE,        // waiting for a request
        ST_RD_ISSUE,    // read pulse waits for ready
        ST_RD_BEATS,    // gathering read beats
        ST_WR_BEATS,    // sending write beats
        ST_RESP         // one cycle response
    } arb_state_t;

    // opcode of the granted request
    typedef enum logic {
        OP_READ,
        OP_WRITE
    } mem_op_t;

    // requesters sharing the memory port
    typedef enum logic {
        SRC_INSTR,
        SRC_DATA
    } req_src_t;

endpackage
